//--- design/cu_setup_pkg.sv
/* Shared widths, FIFO sizing and types for the compute unit setup block.
   Line size must stay a power of two, and FIFO_DEPTH must be a power of two
   with FIFO_PROG_THRESH at most half of it so the pause slack holds. */

package cu_setup_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ADDR_W  = 32;
    localparam int COUNT_W = 32;

    // Cache line geometry
    localparam int LINE_SHIFT = 6;
    localparam int LINE_BYTES = 1 << LINE_SHIFT;

    // ----------------------------------------
    // Request FIFO sizing
    // ----------------------------------------
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_PROG_THRESH = 8;
    localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);

    // One cache-line read request
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              last;
    } read_request_t;

    // Setup FSM states
    typedef enum logic [2:0] {
        SETUP_RESET = 3'd0,
        SETUP_IDLE  = 3'd1,
        SETUP_START = 3'd2,
        SETUP_BUSY  = 3'd3,
        SETUP_PAUSE = 3'd4,
        SETUP_DONE  = 3'd5
    } setup_state_t;

endpackage : cu_setup_pkg

//--- design/setup_control.sv
/* Descriptor register and setup FSM. The descriptor level must stay high and
   stable for the whole run and drop for at least one cycle between runs. */

`timescale 1ns/10ps

module setup_control import cu_setup_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_cu_setup,
    input  logic               descriptor_valid,
    input  logic [ADDR_W-1:0]  descriptor_base,
    input  logic [COUNT_W-1:0] descriptor_count,
    input  logic               engine_idle,
    input  logic               fifo_empty,
    input  logic               fifo_prog_full,
    output logic               engine_start,
    output logic               engine_pause,
    output logic [ADDR_W-1:0]  cfg_base,
    output logic [COUNT_W-1:0] cfg_count,
    output setup_state_t       setup_state
);

    logic               desc_valid_reg;
    logic [ADDR_W-1:0]  desc_base_reg;
    logic [COUNT_W-1:0] desc_count_reg;
    logic               done_reg;
    setup_state_t       next_state;

    // ----------------------------------------
    // Descriptor input register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            desc_valid_reg <= 1'b0;
        end else begin
            desc_valid_reg <= descriptor_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        desc_base_reg  <= descriptor_base;
        desc_count_reg <= descriptor_count;
    end

    // ----------------------------------------
    // Setup FSM
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            setup_state <= SETUP_RESET;
        end else begin
            setup_state <= next_state;
        end
    end

    always_comb begin
        next_state = setup_state;
        case (setup_state)
            SETUP_RESET: next_state = SETUP_IDLE;
            SETUP_IDLE: begin
                if (desc_valid_reg && engine_idle) begin
                    next_state = SETUP_START;
                end
            end
            // Single cycle, the engine sees the start pulse here
            SETUP_START: next_state = SETUP_BUSY;
            SETUP_BUSY: begin
                if (done_reg) begin
                    next_state = SETUP_DONE;
                end else if (fifo_prog_full) begin
                    next_state = SETUP_PAUSE;
                end
            end
            SETUP_PAUSE: begin
                if (!fifo_prog_full) begin
                    next_state = SETUP_BUSY;
                end
            end
            SETUP_DONE: begin
                if (!desc_valid_reg) begin
                    next_state = SETUP_IDLE;
                end
            end
            default: next_state = SETUP_RESET;
        endcase
    end

    // Engine drained and every request popped
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            done_reg <= 1'b0;
        end else begin
            done_reg <= (setup_state == SETUP_BUSY) && engine_idle && fifo_empty;
        end
    end

    // Configuration captured on entry to start, held through the run
    always_ff @(posedge ap_clk) begin
        if ((setup_state == SETUP_IDLE) && (next_state == SETUP_START)) begin
            cfg_base  <= desc_base_reg;
            cfg_count <= desc_count_reg;
        end
    end

    assign engine_start = (setup_state == SETUP_START);
    assign engine_pause = (setup_state == SETUP_PAUSE);

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    start_single_pulse: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        engine_start |=> !engine_start
    );

    // Start only reaches an engine that has finished its previous run
    start_while_idle: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        engine_start |-> engine_idle
    );

endmodule : setup_control

//--- design/serial_read_engine.sv
/* Generates count consecutive cache-line read requests from base. One request
   per cycle at most; the pause level stops issue from the next edge on. */

`timescale 1ns/10ps

module serial_read_engine import cu_setup_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_cu_setup,
    input  logic               engine_start,
    input  logic               engine_pause,
    input  logic [ADDR_W-1:0]  cfg_base,
    input  logic [COUNT_W-1:0] cfg_count,
    output logic               engine_idle,
    output logic               req_wr_en,
    output read_request_t      req_data
);

    logic               active;
    logic [ADDR_W-1:0]  running_addr;
    logic [COUNT_W-1:0] remaining;
    logic               issue;

    // Room to issue this cycle
    assign issue = active && !engine_pause && (remaining != '0);

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            active    <= 1'b0;
            remaining <= '0;
        end else if (engine_start) begin
            active    <= 1'b1;
            remaining <= cfg_count;
        end else if (issue) begin
            remaining <= remaining - COUNT_W'(1);
        end else if (active && (remaining == '0)) begin
            // Drops one cycle after the final request was written out
            active <= 1'b0;
        end
    end

    assign engine_idle = !active;

    // ----------------------------------------
    // Address generation
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_start) begin
            running_addr <= cfg_base;
        end else if (issue) begin
            running_addr <= running_addr + ADDR_W'(LINE_BYTES);
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            req_wr_en <= 1'b0;
        end else begin
            req_wr_en <= issue;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (issue) begin
            req_data.addr <= running_addr;
            req_data.last <= (remaining == COUNT_W'(1));
        end
    end

    // Pause must take effect on the very next edge
    pause_blocks_write: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        engine_pause |=> !req_wr_en
    );

endmodule : serial_read_engine

//--- design/request_fifo.sv
/* Synchronous request FIFO, FIFO_DEPTH entries, with registered read data.
   Writes when full and reads when empty are dropped; callers must avoid them. */

`timescale 1ns/10ps

module request_fifo import cu_setup_pkg::*; (
    input  logic          ap_clk,
    input  logic          areset_cu_setup,
    input  logic          wr_en,
    input  read_request_t din,
    input  logic          rd_en,
    output read_request_t dout,
    output logic          dout_valid,
    output logic          empty,
    output logic          full,
    output logic          prog_full
);

    read_request_t         mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // ----------------------------------------
    // Status flags
    // ----------------------------------------
    assign empty     = (count == '0);
    assign full      = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));
    assign prog_full = (count >= (FIFO_PTR_W+1)'(FIFO_PROG_THRESH));

    // Pointers and occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // Storage and read port
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= do_rd;
        end
    end

    no_write_when_full: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        wr_en |-> !full
    );

    no_read_when_empty: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        rd_en |-> !empty
    );

endmodule : request_fifo

//--- design/cu_setup.sv
/* Setup unit top. A popped request appears on the outputs 3 cycles after
   request_rd_en is driven; setup_busy is high in reset and just after it. */

`timescale 1ns/10ps

module cu_setup import cu_setup_pkg::*; (
    input  logic               ap_clk,
    input  logic               areset_cu_setup,
    input  logic               descriptor_valid,
    input  logic [ADDR_W-1:0]  descriptor_base,
    input  logic [COUNT_W-1:0] descriptor_count,
    input  logic               request_rd_en,
    output logic               request_valid,
    output logic [ADDR_W-1:0]  request_addr,
    output logic               request_last,
    output logic               setup_busy
);

    logic               engine_start;
    logic               engine_pause;
    logic               engine_idle;
    logic [ADDR_W-1:0]  cfg_base;
    logic [COUNT_W-1:0] cfg_count;
    setup_state_t       setup_state;

    logic               req_wr_en;
    read_request_t      req_data;
    logic               rd_en_reg;
    logic               fifo_rd_en;
    read_request_t      fifo_dout;
    logic               fifo_dout_valid;
    logic               fifo_empty;
    logic               fifo_full;
    logic               fifo_prog_full;

    // ----------------------------------------
    // Blocks
    // ----------------------------------------
    setup_control setup_control_inst (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor_valid(descriptor_valid),
        .descriptor_base (descriptor_base),
        .descriptor_count(descriptor_count),
        .engine_idle     (engine_idle),
        .fifo_empty      (fifo_empty),
        .fifo_prog_full  (fifo_prog_full),
        .engine_start    (engine_start),
        .engine_pause    (engine_pause),
        .cfg_base        (cfg_base),
        .cfg_count       (cfg_count),
        .setup_state     (setup_state)
    );

    serial_read_engine serial_read_engine_inst (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .engine_start   (engine_start),
        .engine_pause   (engine_pause),
        .cfg_base       (cfg_base),
        .cfg_count      (cfg_count),
        .engine_idle    (engine_idle),
        .req_wr_en      (req_wr_en),
        .req_data       (req_data)
    );

    request_fifo request_fifo_inst (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .wr_en          (req_wr_en),
        .din            (req_data),
        .rd_en          (fifo_rd_en),
        .dout           (fifo_dout),
        .dout_valid     (fifo_dout_valid),
        .empty          (fifo_empty),
        .full           (fifo_full),
        .prog_full      (fifo_prog_full)
    );

    // ----------------------------------------
    // Pop side and output register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            rd_en_reg     <= 1'b0;
            request_valid <= 1'b0;
            setup_busy    <= 1'b1;
        end else begin
            rd_en_reg     <= request_rd_en;
            request_valid <= fifo_dout_valid;
            setup_busy    <= (setup_state == SETUP_RESET);
        end
    end

    assign fifo_rd_en = rd_en_reg && !fifo_empty;

    always_ff @(posedge ap_clk) begin
        request_addr <= fifo_dout.addr;
        request_last <= fifo_dout.last;
    end

    // Pause at the threshold leaves enough slack that the FIFO never fills
    fifo_never_full: assert property (
        @(posedge ap_clk) disable iff (areset_cu_setup)
        !fifo_full
    );

endmodule : cu_setup

//--- dv/tb_cu_setup.sv
/* Testbench for the setup unit. Drives descriptors and the pop enable, and
   checks each request against expected_addr and the 3-cycle pop latency. */

`timescale 1ns/10ps

module tb_cu_setup import cu_setup_pkg::*; ();

    // About ten times the longest test
    localparam int unsigned CYCLE_LIMIT = 4000;

    logic               ap_clk = 1'b0;
    logic               areset_cu_setup;
    logic               descriptor_valid;
    logic [ADDR_W-1:0]  descriptor_base;
    logic [COUNT_W-1:0] descriptor_count;
    logic               request_rd_en;
    logic               request_valid;
    logic [ADDR_W-1:0]  request_addr;
    logic               request_last;
    logic               setup_busy;

    integer             seed;
    logic [31:0]        rand_word;
    string              test_name;
    int unsigned        test_id;
    logic [ADDR_W-1:0]  exp_base;
    int unsigned        exp_count;

    // Monitor state
    int unsigned        rx_count       = 0;
    int unsigned        seen_test_id   = 0;
    int unsigned        release_cycles = 0;
    logic [2:0]         rd_hist        = 3'b000;
    int unsigned        cycle_count    = 0;
    int unsigned        value_errors   = 0;
    int unsigned        other_errors   = 0;

    cu_setup cu_setup_inst (
        .ap_clk          (ap_clk),
        .areset_cu_setup (areset_cu_setup),
        .descriptor_valid(descriptor_valid),
        .descriptor_base (descriptor_base),
        .descriptor_count(descriptor_count),
        .request_rd_en   (request_rd_en),
        .request_valid   (request_valid),
        .request_addr    (request_addr),
        .request_last    (request_last),
        .setup_busy      (setup_busy)
    );

    always #5 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Reference and helpers
    // ----------------------------------------
    function automatic logic [ADDR_W-1:0] expected_addr(input logic [ADDR_W-1:0] base,
                                                        input int unsigned idx);
        return base + ADDR_W'(idx * LINE_BYTES);
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            value_errors++;
            $display("FAILED %s %s: expected %h, actual %h", name, what, expected, actual);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    task automatic start_test(input string name, input logic [ADDR_W-1:0] base,
                              input int unsigned count);
        test_name        = name;
        test_id          = test_id + 1;
        exp_base         = base;
        exp_count        = count;
        descriptor_base  = base;
        descriptor_count = COUNT_W'(count);
    endtask

    // Holds the descriptor until the last request has been seen, then drops it
    task automatic run_descriptor(input string name, input logic [ADDR_W-1:0] base,
                                  input int unsigned count, input bit random_pop);
        start_test(name, base, count);
        descriptor_valid = 1'b1;
        request_rd_en    = 1'b1;
        while ((seen_test_id != test_id) || (rx_count < count)) begin
            next_cycle();
            if (random_pop) begin
                rand_word     = $random(seed);
                request_rd_en = rand_word[0];
            end
        end
        descriptor_valid = 1'b0;
    endtask

    // ----------------------------------------
    // Monitor and compare
    // ----------------------------------------
    always @(negedge ap_clk) begin
        if (areset_cu_setup) begin
            release_cycles = 0;
            rx_count       = 0;
            rd_hist        = 3'b000;
            check_value("reset", "request_valid", 32'd0, 32'(request_valid));
            check_value("reset", "setup_busy", 32'd1, 32'(setup_busy));
        end else begin
            release_cycles++;
            // Busy clears on the second rising edge after release
            if (release_cycles <= 2) begin
                check_value("reset", "request_valid", 32'd0, 32'(request_valid));
                check_value("reset", "setup_busy", 32'd1, 32'(setup_busy));
            end else begin
                check_value("reset", "setup_busy", 32'd0, 32'(setup_busy));
            end
            if (test_id != seen_test_id) begin
                seen_test_id = test_id;
                rx_count     = 0;
            end
            if (request_valid) begin
                // Pop enable driven 3 cycles back must have been high
                if (!rd_hist[2]) begin
                    other_errors++;
                    $display("ERROR: %s request at %h arrived without a pop grant",
                             test_name, request_addr);
                end
                if (rx_count >= exp_count) begin
                    other_errors++;
                    $display("ERROR: %s produced an extra request at %h",
                             test_name, request_addr);
                end else begin
                    check_value(test_name, $sformatf("addr[%0d]", rx_count),
                                expected_addr(exp_base, rx_count), request_addr);
                    check_value(test_name, $sformatf("last[%0d]", rx_count),
                                32'(rx_count == exp_count - 1), 32'(request_last));
                    rx_count++;
                end
            end
            rd_hist = {rd_hist[1:0], request_rd_en};
        end
    end

    // ----------------------------------------
    // Timeout
    // ----------------------------------------
    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR: timeout after %0d cycles, test %s did not finish",
                     cycle_count, test_name);
            $display("Errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        seed             = 32'hd4f0;
        areset_cu_setup  = 1'b1;
        descriptor_valid = 1'b0;
        descriptor_base  = '0;
        descriptor_count = '0;
        request_rd_en    = 1'b0;
        test_name        = "reset";
        test_id          = 0;
        exp_base         = '0;
        exp_count        = 0;

        repeat (4) @(posedge ap_clk);
        #1;
        areset_cu_setup = 1'b0;
        repeat (6) next_cycle();

        run_descriptor("single_run", 32'h1000, 5, 1'b0);
        repeat (4) next_cycle();

        run_descriptor("back_pressure", 32'h8000_0040, 40, 1'b1);
        repeat (4) next_cycle();

        // Count of zero must produce nothing
        start_test("zero_count", 32'h4000, 0);
        descriptor_valid = 1'b1;
        request_rd_en    = 1'b1;
        repeat (30) next_cycle();
        descriptor_valid = 1'b0;
        next_cycle();

        run_descriptor("back_to_back", 32'h2_0000, 12, 1'b0);
        repeat (10) next_cycle();

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if ((value_errors == 0) && (other_errors == 0)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_cu_setup

//--- vlog.f
design/cu_setup_pkg.sv
design/setup_control.sv
design/serial_read_engine.sv
design/request_fifo.sv
design/cu_setup.sv
dv/tb_cu_setup.sv

//--- run.sh
#!/bin/sh
# Build and run the setup unit testbench with Verilator.
# Exit status is nonzero when the build fails or the log reports failure.

verilator --binary --assert --timescale 1ns/10ps --top-module tb_cu_setup \
    -f vlog.f -o sim_cu_setup \
    && ./obj_dir/sim_cu_setup > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
